// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_entropy_coder
FILELIST := vlog.f
RUNARGS  := +verilator+error+limit+1000

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUNARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: bit_packer.sv
// bit packer
// appends symbol codes MSB first into a 64-bit accumulator, sends full
// 32-bit words, flushes the frame tail and keeps the frame bit total

`default_nettype none
`timescale 1ns/1ps

module bit_packer
    import ec_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sym_valid,
    input  symbol_t     sym,
    output logic        sym_ready,
    output logic        word_valid,
    input  logic        word_ready,
    output out_word_t   word,
    output logic [15:0] bits_generated
);

    localparam int ACC_W  = 2 * WORD_W;
    localparam int CODE_W = 2 + SIZE_W + COEFF_W - 1;   // longest code, 21 bits
    localparam int FILL_W = $clog2(ACC_W + 1);

    logic [ACC_W-1:0]  acc_q;        // left aligned, oldest bit at the top
    logic [FILL_W-1:0] fill_q;
    logic              flush_q;      // last symbol of frame is in
    logic [15:0]       frame_bits_q;
    logic [CODE_W-1:0] code_la;
    logic [FILL_W-1:0] code_len;
    logic              take;
    logic              word_free;
    logic              emit_full;
    logic              emit_last;
    out_word_t         word_next;

    // ============================================================
    // code builder
    // ============================================================
    always_comb begin
        if (sym.is_run) begin
            code_la  = {1'b0, sym.value[RUN_W-1:0], {(CODE_W - 1 - RUN_W){1'b0}}};
            code_len = FILL_W'(1 + RUN_W);
        end else begin
            // magnitude shifted up so its n bits follow the size field
            code_la  = {1'b1, sym.sign, sym.size, sym.value << (COEFF_W - 1 - sym.size)};
            code_len = FILL_W'(2 + SIZE_W) + FILL_W'(sym.size);
        end
    end

    // only one of take / emit_full / emit_last fires per cycle
    assign sym_ready = !flush_q && (fill_q < FILL_W'(WORD_W));
    assign take      = sym_valid && sym_ready;
    assign word_free = !word_valid || word_ready;
    assign emit_full = word_free
                    && ((fill_q > FILL_W'(WORD_W)) || (fill_q == FILL_W'(WORD_W) && !flush_q));
    assign emit_last = word_free && flush_q && !emit_full;

    always_comb begin
        word_next.data      = acc_q[ACC_W-1 -: WORD_W];
        word_next.count     = emit_full ? 6'(WORD_W) : 6'(fill_q);
        word_next.frame_end = emit_last;
    end

    // ============================================================
    // accumulator and frame totals
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q          <= '0;
            fill_q         <= '0;
            flush_q        <= 1'b0;
            frame_bits_q   <= '0;
            bits_generated <= '0;
            word_valid     <= 1'b0;
        end else begin
            if (emit_full || emit_last)
                word_valid <= 1'b1;
            else if (word_ready)
                word_valid <= 1'b0;

            if (take) begin
                acc_q        <= acc_q | ({code_la, {(ACC_W - CODE_W){1'b0}}} >> fill_q);
                fill_q       <= fill_q + code_len;
                frame_bits_q <= frame_bits_q + 16'(code_len);
                flush_q      <= sym.last;
            end else if (emit_full) begin
                acc_q  <= acc_q << WORD_W;
                fill_q <= fill_q - FILL_W'(WORD_W);
            end else if (emit_last) begin
                acc_q          <= '0;      // tail word goes out zero padded
                fill_q         <= '0;
                flush_q        <= 1'b0;
                bits_generated <= frame_bits_q;
                frame_bits_q   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit_full || emit_last)
            word <= word_next;
    end

endmodule

`default_nettype wire

// File: coeff_frame_buffer.sv
// coefficient frame buffer
// fills a frame of quantized coefficients, then replays them in order
// with the last one of the frame flagged

`default_nettype none
`timescale 1ns/1ps

module coeff_frame_buffer
    import ec_pkg::*;
#(
    parameter int DEPTH = MAX_FRAME
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] frame_duration,
    input  logic       quant_valid,
    input  coeff_t     quantized_coeff,
    output logic       quant_ready,
    output logic       rd_valid,
    input  logic       rd_ready,
    output coeff_t     rd_coeff,
    output logic       rd_last
);

    localparam int LW = $clog2(DEPTH + 1);

    coeff_t        mem [DEPTH];
    logic [LW-1:0] wr_ptr;
    logic [LW-1:0] rd_ptr;
    logic [LW-1:0] len_q;      // length of the frame in the buffer
    logic [LW-1:0] cur_len;
    logic          draining;   // 1 while the frame is read out
    logic          wr_fire;
    logic          rd_fire;

    assign quant_ready = !draining;
    assign rd_valid    = draining;
    assign wr_fire     = quant_valid && quant_ready;
    assign rd_fire     = rd_valid && rd_ready;

    // first coefficient takes the length straight from the input
    assign cur_len  = (wr_ptr == '0) ? LW'(frame_len(frame_duration)) : len_q;
    assign rd_coeff = mem[rd_ptr];
    assign rd_last  = (rd_ptr == len_q - 1'b1);

    // ============================================================
    // fill / drain control
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            draining <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            len_q    <= '0;
        end else begin
            if (wr_fire) begin
                if (wr_ptr == '0)
                    len_q <= cur_len;
                if (wr_ptr == cur_len - 1'b1) begin
                    wr_ptr   <= '0;
                    draining <= 1'b1;   // frame full
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (rd_fire) begin
                if (rd_last) begin
                    rd_ptr   <= '0;
                    draining <= 1'b0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire)
            mem[wr_ptr] <= quantized_coeff;
    end

endmodule

`default_nettype wire

// File: ec_pkg.sv
// entropy coder shared definitions
// coefficient, symbol and output word types plus the frame length lookup

`default_nettype none

package ec_pkg;

    // ============================================================
    // field widths
    // ============================================================
    localparam int COEFF_W   = 16;   // quantized coefficient
    localparam int RUN_W     = 8;    // zero run length field
    localparam int SIZE_W    = 4;    // magnitude size field
    localparam int WORD_W    = 32;   // packed output word
    localparam int MAX_FRAME = 640;  // largest frame, sets buffer depth

    typedef logic signed [COEFF_W-1:0] coeff_t;

    // one code symbol, either a zero run or a nonzero coefficient
    typedef struct packed {
        logic              is_run;  // 1: zero run, 0: coefficient
        logic              sign;
        logic [SIZE_W-1:0] size;    // magnitude bits, coefficients only
        logic [COEFF_W-2:0] value;  // run length or magnitude
        logic              last;    // last symbol of the frame
    } symbol_t;

    // packed word as it leaves the coder
    typedef struct packed {
        logic [WORD_W-1:0]      data;       // code bits, MSB first
        logic [$clog2(WORD_W):0] count;     // valid bits, 1 to 32
        logic                   frame_end;
    } out_word_t;

    // frame length from the duration code, 3 falls back to 320
    function automatic int unsigned frame_len(input logic [1:0] code);
        case (code)
            2'd0:    return 160;
            2'd2:    return 640;
            default: return 320;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: entropy_coder_top.sv
// entropy coder top level
// frame buffer -> symbolizer -> symbol FIFO -> bit packer -> word FIFO

`default_nettype none
`timescale 1ns/1ps

module entropy_coder_top
    import ec_pkg::*;
#(
    parameter int FRAME_DEPTH = MAX_FRAME,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        frame_duration,
    input  logic              quant_valid,
    input  coeff_t            quantized_coeff,
    output logic              quant_ready,
    output logic              out_valid,
    output logic [WORD_W-1:0] encoded_bits,
    output logic [5:0]        bit_count,
    output logic              frame_end,
    input  logic              out_ready,
    output logic [15:0]       bits_generated
);

    // buffer read stream
    logic      rd_valid;
    logic      rd_ready;
    coeff_t    rd_coeff;
    logic      rd_last;
    // symbolizer to symbol FIFO
    logic      sz_valid;
    logic      sz_ready;
    symbol_t   sz_sym;
    // symbol FIFO to packer
    logic      pk_valid;
    logic      pk_ready;
    symbol_t   pk_sym;
    // packer to word FIFO
    logic      wd_valid;
    logic      wd_ready;
    out_word_t wd_word;
    out_word_t out_word;

    coeff_frame_buffer #(
        .DEPTH (FRAME_DEPTH)
    ) u_frame_buf (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_duration  (frame_duration),
        .quant_valid     (quant_valid),
        .quantized_coeff (quantized_coeff),
        .quant_ready     (quant_ready),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .rd_coeff        (rd_coeff),
        .rd_last         (rd_last)
    );

    symbolizer u_symbolizer (
        .clk         (clk),
        .rst_n       (rst_n),
        .coeff_valid (rd_valid),
        .coeff       (rd_coeff),
        .coeff_last  (rd_last),
        .coeff_ready (rd_ready),
        .sym_valid   (sz_valid),
        .sym_ready   (sz_ready),
        .sym         (sz_sym)
    );

    sync_fifo #(
        .payload_t (symbol_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_sym_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (sz_valid),
        .in_data   (sz_sym),
        .in_ready  (sz_ready),
        .out_valid (pk_valid),
        .out_ready (pk_ready),
        .out_data  (pk_sym)
    );

    bit_packer u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .sym_valid      (pk_valid),
        .sym            (pk_sym),
        .sym_ready      (pk_ready),
        .word_valid     (wd_valid),
        .word_ready     (wd_ready),
        .word           (wd_word),
        .bits_generated (bits_generated)
    );

    sync_fifo #(
        .payload_t (out_word_t),
        .DEPTH     (FIFO_DEPTH)
    ) u_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wd_valid),
        .in_data   (wd_word),
        .in_ready  (wd_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_word)
    );

    // word fields out to the pins
    assign encoded_bits = out_word.data;
    assign bit_count    = out_word.count;
    assign frame_end    = out_word.frame_end;

endmodule

`default_nettype wire

// File: symbolizer.sv
// coefficient symbolizer
// turns the coefficient stream into zero run symbols and
// sign / size / magnitude symbols for nonzero values

`default_nettype none
`timescale 1ns/1ps

module symbolizer
    import ec_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    coeff_valid,
    input  coeff_t  coeff,
    input  logic    coeff_last,
    output logic    coeff_ready,
    output logic    sym_valid,
    input  logic    sym_ready,
    output symbol_t sym
);

    localparam int RUN_MAX = (1 << RUN_W) - 1;

    logic [RUN_W-1:0] run_q;
    logic [RUN_W-1:0] run_next;
    logic             out_free;
    logic             is_zero;
    logic             split;    // open run ahead of a nonzero coefficient
    logic             emit;
    symbol_t          sym_next;

    function automatic symbol_t run_sym(input logic [RUN_W-1:0] run, input logic last);
        symbol_t s;
        s                  = '0;
        s.is_run           = 1'b1;
        s.value[RUN_W-1:0] = run;
        s.last             = last;
        return s;
    endfunction

    function automatic symbol_t coeff_sym(input coeff_t c, input logic last);
        symbol_t            s;
        logic [COEFF_W-1:0] abs_v;
        logic [COEFF_W-2:0] mag;
        abs_v = c[COEFF_W-1] ? -c : c;
        mag   = abs_v[COEFF_W-1] ? '1 : abs_v[COEFF_W-2:0];  // -32768 saturates
        s        = '0;
        s.sign   = c[COEFF_W-1];
        s.value  = mag;
        s.last   = last;
        for (int i = 0; i < COEFF_W - 1; i++) begin
            if (mag[i])
                s.size = SIZE_W'(i + 1);   // leading one position + 1
        end
        return s;
    endfunction

    assign out_free    = !sym_valid || sym_ready;
    assign is_zero     = (coeff == '0);
    assign split       = coeff_valid && !is_zero && (run_q != '0);
    assign coeff_ready = out_free && !split;

    // ============================================================
    // symbol decision
    // ============================================================
    always_comb begin
        emit     = 1'b0;
        run_next = run_q;
        sym_next = run_sym(run_q, 1'b0);    // flush of open run
        if (coeff_valid && out_free) begin
            if (split) begin
                emit     = 1'b1;
                run_next = '0;
            end else if (is_zero) begin
                if (run_q == RUN_W'(RUN_MAX - 1) || coeff_last) begin
                    emit     = 1'b1;
                    sym_next = run_sym(run_q + 1'b1, coeff_last);
                    run_next = '0;
                end else begin
                    run_next = run_q + 1'b1;
                end
            end else begin
                emit     = 1'b1;
                sym_next = coeff_sym(coeff, coeff_last);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q     <= '0;
            sym_valid <= 1'b0;
        end else begin
            run_q <= run_next;
            if (emit)
                sym_valid <= 1'b1;
            else if (sym_ready)
                sym_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit)
            sym <= sym_next;
    end

endmodule

`default_nettype wire

// File: sync_fifo.sv
// small synchronous FIFO, first word falls through
// payload type is a parameter so one block carries symbols and words

`default_nettype none
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;     // entries held
    logic          push;
    logic          pop;

    assign in_ready  = (count != CW'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
// output checker for the entropy coder
// compares each accepted word with the reference queue, checks the
// coefficients taken per frame and the reported frame bit total

`default_nettype none
`timescale 1ns/1ps

module tb_checker
    import ec_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              quant_valid,
    input  logic              quant_ready,
    input  logic              out_valid,
    input  logic              out_ready,
    input  logic [WORD_W-1:0] encoded_bits,
    input  logic [5:0]        bit_count,
    input  logic              frame_end,
    input  logic [15:0]       bits_generated,
    output int                word_errs,
    output int                frame_errs,
    output int                frames_seen
);

    out_word_t exp_q [$];     // filled by the reference coder
    int        len_q [$];     // coefficients per frame
    int        total_q [$];   // code bits per frame

    out_word_t e;
    int        acc_cnt;       // coefficients taken in the current frame
    int        fill_idx;
    logic      ready_q;

    always @(posedge clk) begin
        if (!rst_n) begin
            word_errs   = 0;
            frame_errs  = 0;
            frames_seen = 0;
            acc_cnt     = 0;
            fill_idx    = 0;
            ready_q     = 1'b1;
        end else begin
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output word %h came with no expected word left", encoded_bits);
                    word_errs++;
                end else begin
                    e = exp_q.pop_front();
                    if (encoded_bits !== e.data) begin
                        $display("ERR encoded_bits exp %h got %h", e.data, encoded_bits);
                        word_errs++;
                    end
                    if (bit_count !== e.count) begin
                        $display("ERR bit_count exp %h got %h", e.count, bit_count);
                        word_errs++;
                    end
                    if (frame_end !== e.frame_end) begin
                        $display("ERR frame_end exp %h got %h", e.frame_end, frame_end);
                        word_errs++;
                    end
                end
                if (frame_end)
                    frames_seen++;
            end
            if (quant_valid && quant_ready)
                acc_cnt++;
            // quant_ready falling, buffer holds a full frame
            if (ready_q && !quant_ready) begin
                if (fill_idx >= len_q.size() || acc_cnt != len_q[fill_idx]) begin
                    $display("frame %0d filled the buffer after %0d coefficients, wrong count",
                             fill_idx, acc_cnt);
                    frame_errs++;
                end
                // previous frame is through the packer by now
                if (fill_idx > 0 && bits_generated !== 16'(total_q[fill_idx - 1])) begin
                    $display("ERR bits_generated exp %h got %h",
                             16'(total_q[fill_idx - 1]), bits_generated);
                    frame_errs++;
                end
                fill_idx++;
                acc_cnt = 0;
            end
            ready_q = quant_ready;
        end
    end

endmodule

`default_nettype wire

// File: tb_entropy_coder.sv
// entropy coder testbench
// sparse LFSR frames sent once with a free output and again under
// random out_ready stalls, checked against a bit-exact reference coder

`default_nettype none
`timescale 1ns/1ps

module tb_entropy_coder
    import ec_pkg::*;
();

    localparam int NF     = 8;   // distinct frames
    localparam int REPLAY = 2;   // frames from here on are sent twice

    logic        clk;
    logic        rst_n;
    logic [1:0]  frame_duration;
    logic        quant_valid;
    coeff_t      quantized_coeff;
    logic        quant_ready;
    logic        out_valid;
    logic [31:0] encoded_bits;
    logic [5:0]  bit_count;
    logic        frame_end;
    logic        out_ready;
    logic [15:0] bits_generated;

    int          frames [NF][MAX_FRAME];
    int          flen [NF];
    logic [1:0]  fcode [NF];
    bit          bitq [$];           // code bits of one frame, oldest first
    logic [31:0] lfsr_q = 32'hdaa8;
    logic        stall_en = 1'b0;
    int unsigned wd_limit;
    int          last_total;
    int          misc_errs;
    int          word_errs;
    int          frame_errs;
    int          frames_seen;

    entropy_coder_top #(
        .FRAME_DEPTH (MAX_FRAME),
        .FIFO_DEPTH  (4)
    ) uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .frame_duration  (frame_duration),
        .quant_valid     (quant_valid),
        .quantized_coeff (quantized_coeff),
        .quant_ready     (quant_ready),
        .out_valid       (out_valid),
        .encoded_bits    (encoded_bits),
        .bit_count       (bit_count),
        .frame_end       (frame_end),
        .out_ready       (out_ready),
        .bits_generated  (bits_generated)
    );

    tb_checker u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .quant_valid    (quant_valid),
        .quant_ready    (quant_ready),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .encoded_bits   (encoded_bits),
        .bit_count      (bit_count),
        .frame_end      (frame_end),
        .bits_generated (bits_generated),
        .word_errs      (word_errs),
        .frame_errs     (frame_errs),
        .frames_seen    (frames_seen)
    );

    // ============================================================
    // stimulus helpers
    // ============================================================
    // fibonacci LFSR, taps 32 22 2 1, one step per bit taken
    function automatic int unsigned lfsr_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int dur_len(input logic [1:0] code);
        case (code)
            2'd0:    return 160;
            2'd1:    return 320;
            2'd2:    return 640;
            default: return 320;
        endcase
    endfunction

    // mostly zeros, small values, now and then an extreme
    function automatic int rand_coeff(input bit sparse);
        int sel;
        int mag;
        if (sparse ? (lfsr_bits(8) != 0) : (lfsr_bits(4) < 11))
            return 0;
        sel = int'(lfsr_bits(3));
        case (sel)
            0: return -32768;
            1: return 32767;
            2: return int'($signed(16'(lfsr_bits(16))));
            default: begin
                mag = int'(lfsr_bits(3)) + 1;
                return (lfsr_bits(1) != 0) ? -mag : mag;
            end
        endcase
    endfunction

    // ============================================================
    // reference coder
    // ============================================================
    function automatic void put_bits(input int unsigned v, input int n);
        for (int i = n - 1; i >= 0; i--)
            bitq.push_back(v[i]);
    endfunction

    // codes frame f into expected words, returns the frame bit total
    function automatic int code_frame(input int f);
        int        run;
        int        c;
        int        mag;
        int        n;
        int        total;
        int        cnt;
        out_word_t w;
        run = 0;
        bitq.delete();
        for (int i = 0; i < flen[f]; i++) begin
            c = frames[f][i];
            if (c == 0) begin
                run++;
                if (run == 255) begin
                    put_bits(255, 9);       // 0 then run 255
                    run = 0;
                end
            end else begin
                if (run > 0)
                    put_bits(run, 9);
                run = 0;
                mag = (c < 0) ? -c : c;
                if (mag > 32767)
                    mag = 32767;
                n = 0;
                for (int b = 0; b < 15; b++) begin
                    if (mag[b])
                        n = b + 1;
                end
                put_bits(1, 1);
                put_bits((c < 0) ? 1 : 0, 1);
                put_bits(n, 4);
                put_bits(mag, n);
            end
        end
        if (run > 0)
            put_bits(run, 9);               // run left open at frame end
        total = bitq.size();
        while (bitq.size() > 0) begin
            w   = '0;
            cnt = 0;
            while (cnt < 32 && bitq.size() > 0) begin
                w.data[31 - cnt] = bitq.pop_front();
                cnt++;
            end
            w.count     = 6'(cnt);
            w.frame_end = (bitq.size() == 0);
            u_chk.exp_q.push_back(w);
        end
        return total;
    endfunction

    task automatic send_frame(input int f);
        u_chk.len_q.push_back(flen[f]);
        last_total = code_frame(f);
        u_chk.total_q.push_back(last_total);
        for (int i = 0; i < flen[f]; i++) begin
            @(negedge clk);
            quant_valid     = 1'b1;
            quantized_coeff = coeff_t'(frames[f][i]);
            // only the first coefficient carries the frame's code
            frame_duration  = (i == 0) ? fcode[f] : fcode[f] ^ 2'd1;
            do begin
                @(posedge clk);
            end while (!quant_ready);
        end
        @(negedge clk);
        quant_valid = 1'b0;
    endtask

    task automatic print_counts();
        $display("errors: word %0d, frame %0d, assertion %0d, other %0d",
                 word_errs, frame_errs, uut.u_sva.fail_cnt, misc_errs);
    endtask

    // ============================================================
    // clock, output stalls, watchdog
    // ============================================================
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        forever begin
            @(negedge clk);
            out_ready = stall_en ? (lfsr_bits(2) != 0) : 1'b1;  // low about 1 in 4
        end
    end

    initial begin
        #1;
        repeat (wd_limit) @(posedge clk);
        $display("timeout: run not finished after %0d clock cycles", wd_limit);
        print_counts();
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        int unsigned n_coeff;
        bit          sparse;
        rst_n           = 1'b0;
        frame_duration  = 2'd0;
        quant_valid     = 1'b0;
        quantized_coeff = '0;
        out_ready       = 1'b1;
        misc_errs       = 0;
        n_coeff         = 0;
        for (int f = 0; f < NF; f++) begin
            if (f < 2)
                fcode[f] = (f == 0) ? 2'd0 : 2'd2;   // all-zero frames
            else if (f < 6)
                fcode[f] = 2'(f - 2);              // each duration code once
            else
                fcode[f] = 2'(lfsr_bits(2));
            flen[f] = dur_len(fcode[f]);
            sparse  = (lfsr_bits(1) != 0);
            for (int i = 0; i < flen[f]; i++)
                frames[f][i] = (f < 2) ? 0 : rand_coeff(sparse);
            n_coeff += (f < REPLAY) ? flen[f] : 2 * flen[f];
        end
        wd_limit = n_coeff * 40 + 2000;

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int f = 0; f < NF; f++)
            send_frame(f);
        @(posedge clk);
        stall_en = 1'b1;
        for (int f = REPLAY; f < NF; f++)
            send_frame(f);

        wait (frames_seen == 2 * NF - REPLAY);
        repeat (4) @(posedge clk);
        if (bits_generated !== 16'(last_total)) begin
            $display("ERR bits_generated exp %h got %h", 16'(last_total), bits_generated);
            misc_errs++;
        end
        if (u_chk.exp_q.size() != 0) begin
            $display("%0d expected words never came out", u_chk.exp_q.size());
            misc_errs++;
        end
        print_counts();
        if (word_errs + frame_errs + uut.u_sva.fail_cnt + misc_errs == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_entropy_coder_sva.sv
// output protocol assertions, bound into the entropy coder top level

`default_nettype none
`timescale 1ns/1ps

module tb_entropy_coder_sva
    import ec_pkg::*;
(
    input logic              clk,
    input logic              rst_n,
    input logic              out_valid,
    input logic              out_ready,
    input logic [WORD_W-1:0] encoded_bits,
    input logic [5:0]        bit_count,
    input logic              frame_end
);

    int fail_cnt = 0;   // failed assertions so far

    // word and its fields hold while the sink stalls
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(encoded_bits)
                                    && $stable(bit_count) && $stable(frame_end))
        else begin
            fail_cnt++;
            $error("output word changed or dropped while out_ready was low");
        end

    a_count: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> bit_count >= 6'd1 && bit_count <= 6'(WORD_W))
        else begin
            fail_cnt++;
            $error("bit_count outside 1 to 32");
        end

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !frame_end |-> bit_count == 6'(WORD_W))
        else begin
            fail_cnt++;
            $error("word without frame_end is not full");
        end

endmodule

bind entropy_coder_top tb_entropy_coder_sva u_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .encoded_bits (encoded_bits),
    .bit_count    (bit_count),
    .frame_end    (frame_end)
);

`default_nettype wire

// File: vlog.f
ec_pkg.sv
sync_fifo.sv
coeff_frame_buffer.sv
symbolizer.sv
bit_packer.sv
entropy_coder_top.sv
tb_entropy_coder_sva.sv
tb_checker.sv
tb_entropy_coder.sv
